//--- apb_periph_top.f
hw/apb_bus_pkg.sv
hw/timer_pkg.sv
hw/timer_channel.sv
hw/timer_regs.sv
hw/apb_slot_decode.sv
hw/ahb_apb_seq.sv
hw/apb_periph_top.sv
sim/tb_apb_periph_top.sv

//--- hw/ahb_apb_seq.sv
//##########################################################
// AHB-lite to APB bridge sequencer
// idle -> setup -> access for mapped slots
// two-cycle error response for unmapped slots
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module ahb_apb_seq (
  input  logic                             i_per_clk,
  input  logic                             i_arst_n,
  input  logic                             i_hsel,
  input  logic [apb_bus_pkg::ADDR_W-1:0]   i_haddr,
  input  logic                             i_hwrite,
  input  logic [apb_bus_pkg::DATA_W-1:0]   i_hwdata,
  input  logic                             i_slot_valid,
  input  logic [apb_bus_pkg::DATA_W-1:0]   i_rdata,
  output logic                             o_hready,
  output apb_bus_pkg::hresp_t              o_hresp,
  output logic [apb_bus_pkg::DATA_W-1:0]   o_hrdata,
  output logic [apb_bus_pkg::ADDR_W-1:0]   o_slot_addr,
  output logic                             o_psel_en,
  output logic                             o_penable,
  output logic                             o_pwrite,
  output logic [apb_bus_pkg::DATA_W-1:0]   o_pwdata,
  output logic [apb_bus_pkg::REG_OFFS_W-1:0] o_paddr
);

  logic [apb_bus_pkg::SEQ_W-1:0]  state_q;
  logic [apb_bus_pkg::SEQ_W-1:0]  state_nxt;
  logic                           accept;
  logic [apb_bus_pkg::ADDR_W-1:0] haddr_q;
  logic                           hwrite_q;
  logic [apb_bus_pkg::DATA_W-1:0] pwdata_q;
  logic [apb_bus_pkg::DATA_W-1:0] hrdata_q;

  // ready in idle and in the last error cycle
  assign o_hready = (state_q == apb_bus_pkg::SEQ_IDLE) || (state_q == apb_bus_pkg::SEQ_ERR2);
  assign o_hresp  = ((state_q == apb_bus_pkg::SEQ_ERR1) || (state_q == apb_bus_pkg::SEQ_ERR2))
                    ? apb_bus_pkg::HRESP_ERROR : apb_bus_pkg::HRESP_OKAY;
  assign accept   = i_hsel && o_hready;

  // live address while ready so the slot check lines up with accept
  assign o_slot_addr = o_hready ? i_haddr : haddr_q;

  // APB control from state
  assign o_psel_en = (state_q == apb_bus_pkg::SEQ_SETUP) || (state_q == apb_bus_pkg::SEQ_ACCESS);
  assign o_penable = (state_q == apb_bus_pkg::SEQ_ACCESS);
  assign o_pwrite  = hwrite_q;
  assign o_paddr   = haddr_q[apb_bus_pkg::REG_OFFS_W-1:0];
  assign o_hrdata  = hrdata_q;

  // setup is the AHB data phase and takes hwdata straight through
  assign o_pwdata = (state_q == apb_bus_pkg::SEQ_SETUP) ? i_hwdata : pwdata_q;

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      apb_bus_pkg::SEQ_IDLE, apb_bus_pkg::SEQ_ERR2: begin
        if (accept) begin
          state_nxt = i_slot_valid ? apb_bus_pkg::SEQ_SETUP : apb_bus_pkg::SEQ_ERR1;
        end else begin
          state_nxt = apb_bus_pkg::SEQ_IDLE;
        end
      end
      apb_bus_pkg::SEQ_SETUP:  state_nxt = apb_bus_pkg::SEQ_ACCESS;
      apb_bus_pkg::SEQ_ACCESS: state_nxt = apb_bus_pkg::SEQ_IDLE;
      apb_bus_pkg::SEQ_ERR1:   state_nxt = apb_bus_pkg::SEQ_ERR2;
      default:                 state_nxt = apb_bus_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge i_per_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q  <= apb_bus_pkg::SEQ_IDLE;
      hwrite_q <= 1'b0;
    end else begin
      state_q <= state_nxt;
      if (accept) begin
        hwrite_q <= i_hwrite;
      end
    end
  end

  // address, write data and read data
  always_ff @(posedge i_per_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      haddr_q  <= '0;
      pwdata_q <= '0;
      hrdata_q <= '0;
    end else begin
      if (accept) begin
        haddr_q <= i_haddr;
      end
      if (state_q == apb_bus_pkg::SEQ_SETUP) begin
        pwdata_q <= i_hwdata;
      end
      // sampled at end of access and shown in completion cycle
      if (state_q == apb_bus_pkg::SEQ_ACCESS) begin
        hrdata_q <= i_rdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/apb_bus_pkg.sv
//##########################################################
// AHB/APB fabric definitions: address map, bus widths,
// AHB response codes and bridge sequencer state codes
//##########################################################
`default_nettype none

package apb_bus_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // slot field sits at haddr[15:12]
  localparam int SLOT_LSB  = 12;
  localparam int SLOT_W    = 4;
  localparam int NUM_SLOTS = 2;

  localparam logic [SLOT_W-1:0] SLOT_TIMER0 = 4'd0;
  localparam logic [SLOT_W-1:0] SLOT_TIMER1 = 4'd1;

  // offset bits forwarded to every peripheral
  localparam int REG_OFFS_W = 8;

  // AHB response, only two codes used here
  typedef logic [1:0] hresp_t;
  localparam hresp_t HRESP_OKAY  = 2'b00;
  localparam hresp_t HRESP_ERROR = 2'b01;

  // bridge sequencer states
  localparam int SEQ_W = 3;
  localparam logic [SEQ_W-1:0] SEQ_IDLE   = 3'd0;
  localparam logic [SEQ_W-1:0] SEQ_SETUP  = 3'd1;
  localparam logic [SEQ_W-1:0] SEQ_ACCESS = 3'd2;
  localparam logic [SEQ_W-1:0] SEQ_ERR1   = 3'd3;
  localparam logic [SEQ_W-1:0] SEQ_ERR2   = 3'd4;

endpackage

`default_nettype wire

//--- hw/apb_periph_top.sv
//##########################################################
// peripheral top: AHB-lite to APB bridge, slot decoder
// and two timer blocks, interrupts as one vector
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module apb_periph_top (
  input  logic                                   i_per_clk,
  input  logic                                   i_arst_n,
  input  logic                                   i_hsel,
  input  logic [apb_bus_pkg::ADDR_W-1:0]         i_haddr,
  input  logic                                   i_hwrite,
  input  logic [apb_bus_pkg::DATA_W-1:0]         i_hwdata,
  output logic                                   o_hready,
  output apb_bus_pkg::hresp_t                    o_hresp,
  output logic [apb_bus_pkg::DATA_W-1:0]         o_hrdata,
  output logic [2*timer_pkg::TIMER_CHANNELS-1:0] o_int_vld
);

  // shared APB fabric
  logic [apb_bus_pkg::ADDR_W-1:0]     slot_addr;
  logic                               slot_valid;
  logic                               psel_en;
  logic                               penable;
  logic                               pwrite;
  logic [apb_bus_pkg::DATA_W-1:0]     pwdata;
  logic [apb_bus_pkg::REG_OFFS_W-1:0] paddr;
  logic [apb_bus_pkg::DATA_W-1:0]     rdata;
  // per slot
  logic                               psel0;
  logic                               psel1;
  logic [apb_bus_pkg::DATA_W-1:0]     prdata0;
  logic [apb_bus_pkg::DATA_W-1:0]     prdata1;

  ahb_apb_seq x_ahb_apb_seq (
    .i_per_clk    (i_per_clk ),
    .i_arst_n     (i_arst_n  ),
    .i_hsel       (i_hsel    ),
    .i_haddr      (i_haddr   ),
    .i_hwrite     (i_hwrite  ),
    .i_hwdata     (i_hwdata  ),
    .i_slot_valid (slot_valid),
    .i_rdata      (rdata     ),
    .o_hready     (o_hready  ),
    .o_hresp      (o_hresp   ),
    .o_hrdata     (o_hrdata  ),
    .o_slot_addr  (slot_addr ),
    .o_psel_en    (psel_en   ),
    .o_penable    (penable   ),
    .o_pwrite     (pwrite    ),
    .o_pwdata     (pwdata    ),
    .o_paddr      (paddr     )
  );

  apb_slot_decode x_slot_decode (
    .i_slot_addr  (slot_addr ),
    .i_psel_en    (psel_en   ),
    .i_prdata0    (prdata0   ),
    .i_prdata1    (prdata1   ),
    .o_psel0      (psel0     ),
    .o_psel1      (psel1     ),
    .o_slot_valid (slot_valid),
    .o_rdata      (rdata     )
  );

  // slot 0, interrupts in the low bits
  timer_regs x_timer0 (
    .i_per_clk (i_per_clk                                  ),
    .i_arst_n  (i_arst_n                                   ),
    .i_psel    (psel0                                      ),
    .i_penable (penable                                    ),
    .i_pwrite  (pwrite                                     ),
    .i_paddr   (paddr                                      ),
    .i_pwdata  (pwdata                                     ),
    .o_prdata  (prdata0                                    ),
    .o_int     (o_int_vld[timer_pkg::TIMER_CHANNELS-1:0]   )
  );

  // slot 1, interrupts in the high bits
  timer_regs x_timer1 (
    .i_per_clk (i_per_clk                                                        ),
    .i_arst_n  (i_arst_n                                                         ),
    .i_psel    (psel1                                                            ),
    .i_penable (penable                                                          ),
    .i_pwrite  (pwrite                                                           ),
    .i_paddr   (paddr                                                            ),
    .i_pwdata  (pwdata                                                           ),
    .o_prdata  (prdata1                                                          ),
    .o_int     (o_int_vld[2*timer_pkg::TIMER_CHANNELS-1:timer_pkg::TIMER_CHANNELS])
  );

endmodule

`default_nettype wire

//--- hw/apb_slot_decode.sv
//##########################################################
// APB slot decoder: slot select from the address
// and read-data multiplexer
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module apb_slot_decode (
  input  logic [apb_bus_pkg::ADDR_W-1:0] i_slot_addr,
  input  logic                           i_psel_en,
  input  logic [apb_bus_pkg::DATA_W-1:0] i_prdata0,
  input  logic [apb_bus_pkg::DATA_W-1:0] i_prdata1,
  output logic                           o_psel0,
  output logic                           o_psel1,
  output logic                           o_slot_valid,
  output logic [apb_bus_pkg::DATA_W-1:0] o_rdata
);

  logic [apb_bus_pkg::SLOT_W-1:0]    slot;
  logic [apb_bus_pkg::NUM_SLOTS-1:0] slot_hit;

  // slot field of the address
  assign slot = i_slot_addr[apb_bus_pkg::SLOT_LSB +: apb_bus_pkg::SLOT_W];

  // fixed map, one hit bit per slot
  assign slot_hit[0] = (slot == apb_bus_pkg::SLOT_TIMER0);
  assign slot_hit[1] = (slot == apb_bus_pkg::SLOT_TIMER1);

  // anything else gets the error response
  assign o_slot_valid = |slot_hit;

  assign o_psel0 = i_psel_en && slot_hit[0];
  assign o_psel1 = i_psel_en && slot_hit[1];

  // read data of the addressed slot, zero if unmapped
  always_comb begin
    o_rdata = '0;
    if (slot_hit[0]) begin
      o_rdata = i_prdata0;
    end
    if (slot_hit[1]) begin
      o_rdata = i_prdata1;
    end
  end

endmodule

`default_nettype wire

//--- hw/timer_channel.sv
//##########################################################
// timer channel: reloading down counter
// with a one-cycle expiry flag
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module timer_channel (
  input  logic                           i_per_clk,
  input  logic                           i_arst_n,
  input  logic                           i_load_we,
  input  logic [apb_bus_pkg::DATA_W-1:0] i_load_val,
  input  logic                           i_enable,
  output logic [timer_pkg::CNT_W-1:0]    o_count,
  output logic                           o_expire
);

  logic [timer_pkg::CNT_W-1:0] count_q;

  assign o_count = count_q;

  // high while the counter reads 0 and is running
  // the reload and the status set take place on this edge
  assign o_expire = i_enable && !i_load_we && (count_q == '0);

  always_ff @(posedge i_per_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      count_q <= '0;
    end else if (i_load_we) begin
      // bus write of LOAD restarts the count
      count_q <= i_load_val;
    end else if (i_enable) begin
      if (count_q == '0) begin
        count_q <= i_load_val;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/timer_pkg.sv
//##########################################################
// timer block definitions: channel count, counter width,
// register offsets and control bit positions
//##########################################################
`default_nettype none

package timer_pkg;

  localparam int TIMER_CHANNELS = 2;
  localparam int CNT_W          = 32;

  // offset bit 4 picks the channel, stride 0x10
  localparam int CH_SEL_BIT = 4;

  // register offsets inside one channel
  localparam logic [CH_SEL_BIT-1:0] REG_LOAD   = 4'h0;
  localparam logic [CH_SEL_BIT-1:0] REG_VALUE  = 4'h4;
  localparam logic [CH_SEL_BIT-1:0] REG_CTRL   = 4'h8;
  localparam logic [CH_SEL_BIT-1:0] REG_INTCLR = 4'hC;

  // control register bits
  localparam int CTRL_EN_BIT = 0;
  localparam int CTRL_IE_BIT = 1;

endpackage

`default_nettype wire

//--- hw/timer_regs.sv
//##########################################################
// timer block register file: load, control and status
// per channel, interrupt mask, APB read mux
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module timer_regs (
  input  logic                                   i_per_clk,
  input  logic                                   i_arst_n,
  input  logic                                   i_psel,
  input  logic                                   i_penable,
  input  logic                                   i_pwrite,
  input  logic [apb_bus_pkg::REG_OFFS_W-1:0]     i_paddr,
  input  logic [apb_bus_pkg::DATA_W-1:0]         i_pwdata,
  output logic [apb_bus_pkg::DATA_W-1:0]         o_prdata,
  output logic [timer_pkg::TIMER_CHANNELS-1:0]   o_int
);

  logic                                wr_en;
  logic [timer_pkg::CH_SEL_BIT-1:0]    reg_offs;
  logic [apb_bus_pkg::DATA_W-1:0]      ch_rdata [timer_pkg::TIMER_CHANNELS];

  // writes land on the access cycle
  assign wr_en    = i_psel && i_penable && i_pwrite;
  assign reg_offs = i_paddr[timer_pkg::CH_SEL_BIT-1:0];

  for (genvar c = 0; c < timer_pkg::TIMER_CHANNELS; c++) begin : g_ch
    logic                            ch_hit;
    logic                            load_we;
    logic                            ctrl_we;
    logic                            clr_we;
    logic                            expire;
    logic [timer_pkg::CNT_W-1:0]     load_q;
    logic [timer_pkg::CNT_W-1:0]     load_src;
    logic [timer_pkg::CNT_W-1:0]     count;
    logic [timer_pkg::CTRL_IE_BIT:0] ctrl_q;
    logic                            status_q;

    assign ch_hit  = (i_paddr[timer_pkg::CH_SEL_BIT] == 1'(c));
    assign load_we = wr_en && ch_hit && (reg_offs == timer_pkg::REG_LOAD);
    assign ctrl_we = wr_en && ch_hit && (reg_offs == timer_pkg::REG_CTRL);
    assign clr_we  = wr_en && ch_hit && (reg_offs == timer_pkg::REG_INTCLR);

    // new value goes to the counter in the same edge as load_q
    assign load_src = load_we ? i_pwdata : load_q;

    always_ff @(posedge i_per_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        load_q   <= '0;
        ctrl_q   <= '0;
        status_q <= 1'b0;
      end else begin
        if (load_we) begin
          load_q <= i_pwdata;
        end
        if (ctrl_we) begin
          ctrl_q <= i_pwdata[timer_pkg::CTRL_IE_BIT:0];
        end
        // expiry wins over a clear in the same cycle
        if (expire) begin
          status_q <= 1'b1;
        end else if (clr_we) begin
          status_q <= 1'b0;
        end
      end
    end

    timer_channel x_channel (
      .i_per_clk  (i_per_clk                      ),
      .i_arst_n   (i_arst_n                       ),
      .i_load_we  (load_we                        ),
      .i_load_val (load_src                       ),
      .i_enable   (ctrl_q[timer_pkg::CTRL_EN_BIT] ),
      .o_count    (count                          ),
      .o_expire   (expire                         )
    );

    // masked interrupt
    assign o_int[c] = status_q && ctrl_q[timer_pkg::CTRL_IE_BIT];

    // per-channel read mux, VALUE is read only
    always_comb begin
      case (reg_offs)
        timer_pkg::REG_LOAD:   ch_rdata[c] = load_q;
        timer_pkg::REG_VALUE:  ch_rdata[c] = count;
        timer_pkg::REG_CTRL:   ch_rdata[c] = {{(apb_bus_pkg::DATA_W-timer_pkg::CTRL_IE_BIT-1){1'b0}},
                                              ctrl_q};
        timer_pkg::REG_INTCLR: ch_rdata[c] = {{(apb_bus_pkg::DATA_W-1){1'b0}}, status_q};
        default:               ch_rdata[c] = '0;
      endcase
    end
  end

  // drive read data only while selected
  assign o_prdata = i_psel ? ch_rdata[i_paddr[timer_pkg::CH_SEL_BIT]] : '0;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_apb_periph_top \
  -f apb_periph_top.f \
  -o tb_apb_periph_top

./obj_dir/tb_apb_periph_top | tee sim.log

if grep -qx "All checks passed" sim.log; then
  echo "simulation PASS"
  exit 0
fi
echo "simulation FAIL"
exit 1

//--- sim/tb_apb_periph_top.sv
//##########################################################
// testbench for apb_periph_top: AHB transfer tasks,
// handshake assertions and timer behavior checks
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module tb_apb_periph_top;

  // all tests together stay well under 1000 cycles
  localparam int TIMEOUT_CYCLES = 5000;
  localparam int INT_W          = 2 * timer_pkg::TIMER_CHANNELS;

  logic                clk;
  logic                arst_n;
  logic                hsel;
  logic [31:0]         haddr;
  logic                hwrite;
  logic [31:0]         hwdata;
  logic                hready;
  apb_bus_pkg::hresp_t hresp;
  logic [31:0]         hrdata;
  logic [INT_W-1:0]    int_vld;

  integer seed;
  int     errors;
  int     checks;
  int     test_errors;
  int     cycle_cnt;
  logic   acc_map;
  logic   acc_unm;

  apb_periph_top dut_i (
    .i_per_clk (clk    ),
    .i_arst_n  (arst_n ),
    .i_hsel    (hsel   ),
    .i_haddr   (haddr  ),
    .i_hwrite  (hwrite ),
    .i_hwdata  (hwdata ),
    .o_hready  (hready ),
    .o_hresp   (hresp  ),
    .o_hrdata  (hrdata ),
    .o_int_vld (int_vld)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // accepted transfers, slots 0 and 1 are mapped
  assign acc_map = hsel && hready && (haddr[15:12] < 4'd2);
  assign acc_unm = hsel && hready && (haddr[15:12] >= 4'd2);

  // setup and access cycles of a mapped transfer
  assert property (@(posedge clk) disable iff (!arst_n)
    ($past(acc_map) || $past(acc_map, 2)) |-> !hready && hresp == apb_bus_pkg::HRESP_OKAY)
    else begin
      $display("MISMATCH t=%0t o_hready/o_hresp expected 0/0 got %b/%0d", $time, hready, hresp);
      errors++;
    end
  // completion cycle
  assert property (@(posedge clk) disable iff (!arst_n)
    $past(acc_map, 3) |-> hready && hresp == apb_bus_pkg::HRESP_OKAY)
    else begin
      $display("MISMATCH t=%0t o_hready/o_hresp expected 1/0 got %b/%0d", $time, hready, hresp);
      errors++;
    end
  // two-cycle error response
  assert property (@(posedge clk) disable iff (!arst_n)
    $past(acc_unm) |-> !hready && hresp == apb_bus_pkg::HRESP_ERROR)
    else begin
      $display("MISMATCH t=%0t o_hready/o_hresp expected 0/1 got %b/%0d", $time, hready, hresp);
      errors++;
    end
  assert property (@(posedge clk) disable iff (!arst_n)
    $past(acc_unm, 2) |-> hready && hresp == apb_bus_pkg::HRESP_ERROR)
    else begin
      $display("MISMATCH t=%0t o_hready/o_hresp expected 1/1 got %b/%0d", $time, hready, hresp);
      errors++;
    end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("MISMATCH t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
      errors++;
    end
  endtask

  // slot at [15:12], channel at bit 4, register in [3:0]
  function automatic logic [31:0] addr_of(input logic [3:0] slot, input logic ch,
                                          input logic [3:0] offs);
    return {16'h0, slot, 7'h0, ch, offs};
  endfunction

  // one AHB transfer, address phase held until ready
  task automatic ahb_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    int     low_cycles;
    int     exp_low;
    logic   mapped;
    mapped     = addr[15:12] < 4'd2;
    exp_low    = mapped ? 2 : 1;
    low_cycles = 0;
    @(posedge clk);
    hsel   <= 1'b1;
    haddr  <= addr;
    hwrite <= wr;
    @(negedge clk);
    while (!hready) @(negedge clk);
    // accept edge, data phase follows
    @(posedge clk);
    hsel   <= 1'b0;
    hwdata <= wdata;
    @(negedge clk);
    while (!hready) begin
      low_cycles++;
      @(negedge clk);
    end
    rdata = hrdata;
    check_value("o_hready low cycles", exp_low, low_cycles);
    check_value("o_hresp", mapped ? 32'd0 : 32'd1, {30'h0, hresp});
  endtask

  task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    ahb_xfer(addr, 1'b1, data, unused_rd);
  endtask

  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
    ahb_xfer(addr, 1'b0, 32'h0, data);
  endtask

  // poll one interrupt bit, give up after limit cycles
  task automatic wait_int(input int bit_idx, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!int_vld[bit_idx] && cycles < limit) begin
      cycles++;
      @(negedge clk);
    end
    checks++;
    assert (int_vld[bit_idx]) else begin
      $display("interrupt bit %0d did not rise within %0d cycles", bit_idx, limit);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %-12s %s, %0d errors", name,
             (errors == test_errors) ? "ok" : "FAILED", errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] load_val;
    int          n;
    seed        = 32'h4d165fb0;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    hsel        = 1'b0;
    haddr       = 32'h0;
    hwrite      = 1'b0;
    hwdata      = 32'h0;
    arst_n      = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    // reset state
    @(negedge clk);
    check_value("o_hready", 32'd1, {31'h0, hready});
    check_value("o_hresp", 32'd0, {30'h0, hresp});
    check_value("o_int_vld", 32'd0, {28'h0, int_vld});
    finish_test("reset");

    // LOAD sets the counter too, VALUE ignores writes
    load_val = $random(seed);
    ahb_write(addr_of(4'd0, 1'b0, timer_pkg::REG_LOAD), load_val);
    ahb_read(addr_of(4'd0, 1'b0, timer_pkg::REG_LOAD), rd);
    check_value("o_hrdata LOAD", load_val, rd);
    ahb_write(addr_of(4'd0, 1'b0, timer_pkg::REG_VALUE), ~load_val);
    ahb_read(addr_of(4'd0, 1'b0, timer_pkg::REG_VALUE), rd);
    check_value("o_hrdata VALUE", load_val, rd);
    finish_test("write_read");

    // slot 5 is unmapped, ERROR checked inside the transfer
    ahb_read(32'h0000_5000, rd);
    ahb_read(addr_of(4'd0, 1'b0, timer_pkg::REG_LOAD), rd);
    check_value("o_hrdata LOAD after error", load_val, rd);
    finish_test("unmapped");

    // expiry on slot 0 channel 0
    n = 4 + int'($unsigned($random(seed)) % 17);
    ahb_write(addr_of(4'd0, 1'b0, timer_pkg::REG_LOAD), n);
    ahb_write(addr_of(4'd0, 1'b0, timer_pkg::REG_CTRL), 32'h2);
    ahb_write(addr_of(4'd0, 1'b0, timer_pkg::REG_CTRL), 32'h3);
    wait_int(0, n + 10);
    // stop the count before the next expiry, then clear
    ahb_write(addr_of(4'd0, 1'b0, timer_pkg::REG_CTRL), 32'h2);
    ahb_write(addr_of(4'd0, 1'b0, timer_pkg::REG_INTCLR), 32'h0);
    check_value("o_int_vld[0]", 32'd0, {31'h0, int_vld[0]});
    ahb_read(addr_of(4'd0, 1'b0, timer_pkg::REG_INTCLR), rd);
    check_value("o_hrdata INTCLR", 32'd0, rd);
    finish_test("expiry");

    // slot 0 channel 1 runs with its interrupt masked
    n = 4 + int'($unsigned($random(seed)) % 17);
    ahb_write(addr_of(4'd0, 1'b1, timer_pkg::REG_LOAD), n);
    ahb_write(addr_of(4'd0, 1'b1, timer_pkg::REG_CTRL), 32'h1);
    repeat (n + 10) begin
      @(negedge clk);
      check_value("o_int_vld[1]", 32'd0, {31'h0, int_vld[1]});
    end
    ahb_read(addr_of(4'd0, 1'b1, timer_pkg::REG_INTCLR), rd);
    check_value("o_hrdata INTCLR", 32'd1, rd);
    ahb_write(addr_of(4'd0, 1'b1, timer_pkg::REG_CTRL), 32'h0);
    ahb_write(addr_of(4'd0, 1'b1, timer_pkg::REG_INTCLR), 32'h0);
    finish_test("masking");

    // slot 1 channel 1 maps to o_int_vld bit 3 only
    n = 4 + int'($unsigned($random(seed)) % 17);
    ahb_write(addr_of(4'd1, 1'b1, timer_pkg::REG_LOAD), n);
    ahb_write(addr_of(4'd1, 1'b1, timer_pkg::REG_CTRL), 32'h3);
    ahb_read(addr_of(4'd1, 1'b1, timer_pkg::REG_VALUE), rd);
    checks++;
    assert (rd <= n) else begin
      $display("MISMATCH t=%0t o_hrdata VALUE expected <= 0x%08h got 0x%08h", $time, n, rd);
      errors++;
    end
    wait_int(3, n + 10);
    check_value("o_int_vld", 32'h8, {28'h0, int_vld});
    finish_test("independence");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, tests did not finish", TIMEOUT_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire
